// File: verilog/aud_pkg.sv
`default_nettype none

package aud_pkg;

    // datapath widths
    localparam int SAMPLE_W = 16;
    localparam int ADDR_W   = 20;
    localparam int SPEED_W  = 8;
    localparam int PHASE_W  = 3;   // phases 0..7
    localparam int STEP_W   = 4;   // fast step 1..8
    localparam int SHIFT_W  = 2;   // log2 of slow period

    // two flops before the edge detector
    localparam int SYNC_STAGES = 2;

    localparam logic [ADDR_W-1:0] START_ADDR = '0;

    // fast codes carry the step in bits 6:3
    typedef enum logic [SPEED_W-1:0] {
        SPD_HALF    = 8'd1,
        SPD_QUARTER = 8'd3,
        SPD_EIGHTH  = 8'd7,
        SPD_X1      = 8'd8,
        SPD_X2      = 8'd16,
        SPD_X3      = 8'd24,
        SPD_X4      = 8'd32,
        SPD_X5      = 8'd40,
        SPD_X6      = 8'd48,
        SPD_X7      = 8'd56,
        SPD_X8      = 8'd64
    } speed_t;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_PLAY  = 2'd1,
        ST_PAUSE = 2'd2,
        ST_STOP  = 2'd3
    } state_t;

    // log2 of the slow period, 0 means fast playback
    function automatic logic [SHIFT_W-1:0] slow_shift(speed_t spd);
        case (spd)
            SPD_HALF:    return 2'd1;
            SPD_QUARTER: return 2'd2;
            SPD_EIGHTH:  return 2'd3;
            default:     return 2'd0;
        endcase
    endfunction

    // words skipped per tick, unknown codes play at 1x
    function automatic logic [STEP_W-1:0] fast_step(speed_t spd);
        case (spd)
            SPD_X1, SPD_X2, SPD_X3, SPD_X4,
            SPD_X5, SPD_X6, SPD_X7, SPD_X8: return spd[6:3];
            default:                        return 4'd1;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: verilog/play_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module play_ctrl
    import aud_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_rst_n,
    input  wire         i_start,
    input  wire         i_pause,
    input  wire         i_stop,
    input  wire         i_daclrck,
    input  wire         i_player_ack,
    input  wire speed_t i_speed,
    input  wire         i_end_hit,
    output logic        o_play_tick,
    output speed_t      o_speed,
    output logic        o_clear,
    output logic        o_player_en
);

    state_t state_q;
    state_t state_nxt;

    logic [SYNC_STAGES:0] lrck_q;  // sync flops plus one history flop
    logic                 tick;
    logic                 enter_play;
    logic                 enter_idle;

    // left/right clock into i_clk domain
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lrck_q <= '0;
        end else begin
            lrck_q <= {lrck_q[SYNC_STAGES-1:0], i_daclrck};
        end
    end

    // falling edge of the synchronised lrck
    assign tick = lrck_q[SYNC_STAGES] & ~lrck_q[SYNC_STAGES-1];

    assign o_play_tick = tick && (state_q == ST_PLAY);

    // transport FSM
    always_comb begin
        state_nxt = state_q;
        case (state_q)
            ST_IDLE: begin
                if (i_start) begin
                    state_nxt = ST_PLAY;
                end
            end
            ST_PLAY: begin
                if (i_stop) begin   // stop has priority over pause
                    state_nxt = ST_STOP;
                end else if (i_pause) begin
                    state_nxt = ST_PAUSE;
                end else if (o_play_tick && i_end_hit) begin
                    state_nxt = ST_IDLE;  // last sample still goes out
                end
            end
            ST_PAUSE: begin
                if (i_start) begin
                    state_nxt = ST_PLAY;
                end else if (i_stop) begin
                    state_nxt = ST_STOP;
                end
            end
            ST_STOP: begin
                state_nxt = ST_IDLE;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    assign enter_play = (state_nxt == ST_PLAY) && (state_q != ST_PLAY);
    assign enter_idle = (state_nxt == ST_IDLE) && (state_q != ST_IDLE);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= ST_IDLE;
            o_clear <= 1'b0;
        end else begin
            state_q <= state_nxt;
            o_clear <= enter_idle;  // high for the first idle cycle
        end
    end

    // speed only changes when playback (re)starts
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_speed <= SPD_X1;
        end else if (enter_play) begin
            o_speed <= i_speed;
        end
    end

    // sample-ready flag toward the player
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_player_en <= 1'b0;
        end else if (o_play_tick) begin
            o_player_en <= 1'b1;  // a new sample beats the ack
        end else if (i_player_ack || (state_q != ST_PLAY)) begin
            o_player_en <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/addr_seq.sv
`timescale 1ns/100ps
`default_nettype none

module addr_seq
    import aud_pkg::*;
(
    input  wire                i_clk,
    input  wire                i_rst_n,
    input  wire                i_play_tick,
    input  wire                i_clear,
    input  wire speed_t        i_speed,
    input  wire                i_linear,
    input  wire [ADDR_W-1:0]   i_last_addr,
    output logic [ADDR_W-1:0]  o_sram_addr,
    output logic [PHASE_W-1:0] o_phase,
    output logic               o_end_hit
);

    logic [SHIFT_W-1:0] shift;
    logic               slow;
    logic [PHASE_W-1:0] last_phase;  // N-1
    logic [STEP_W-1:0]  adv;
    logic [ADDR_W:0]    addr_sum;    // one spare bit for the overflow
    logic [PHASE_W-1:0] phase_nxt;

    assign shift      = slow_shift(i_speed);
    assign slow       = (shift != '0);
    assign last_phase = PHASE_W'((1 << shift) - 1);

    // how far this tick moves the address
    always_comb begin
        adv = '0;
        if (!slow) begin
            adv = fast_step(i_speed);
        end else if (i_linear) begin
            if (o_phase == '0) begin
                adv = 4'd1;  // next word needed for the blend
            end
        end else if (o_phase == last_phase) begin
            adv = 4'd1;
        end
    end

    always_comb begin
        if (!slow || (o_phase == last_phase)) begin
            phase_nxt = '0;
        end else begin
            phase_nxt = o_phase + 1'b1;
        end
    end

    assign addr_sum = {1'b0, o_sram_addr} + (ADDR_W + 1)'(adv);

    // past the recording, so this is the final sample
    assign o_end_hit = i_play_tick && (addr_sum > {1'b0, i_last_addr});

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_sram_addr <= START_ADDR;
            o_phase     <= '0;
        end else if (i_clear) begin
            o_sram_addr <= START_ADDR;
            o_phase     <= '0;
        end else if (i_play_tick) begin
            o_phase <= phase_nxt;
            if (!o_end_hit) begin
                o_sram_addr <= addr_sum[ADDR_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/interp.sv
`timescale 1ns/100ps
`default_nettype none

module interp
    import aud_pkg::*;
(
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  wire                        i_play_tick,
    input  wire speed_t                i_speed,
    input  wire                        i_linear,
    input  wire [PHASE_W-1:0]          i_phase,
    input  wire [SAMPLE_W-1:0]         i_sram_data,
    output logic signed [SAMPLE_W-1:0] o_dac_data
);

    localparam int WGT_W   = PHASE_W + 1;           // weights up to 8
    localparam int BLEND_W = SAMPLE_W + WGT_W + 1;

    logic [SHIFT_W-1:0]         shift;
    logic                       blend_mode;
    logic [WGT_W-1:0]           n_val;
    logic [WGT_W-1:0]           wgt_cur;
    logic [WGT_W-1:0]           wgt_prev;
    logic signed [SAMPLE_W-1:0] prev_q;
    logic signed [SAMPLE_W-1:0] cur;
    logic signed [BLEND_W-1:0]  blend;
    logic signed [BLEND_W-1:0]  blend_sh;
    logic signed [SAMPLE_W-1:0] sample_nxt;

    assign shift = slow_shift(i_speed);
    assign cur   = $signed(i_sram_data);

    // only linear slow mode blends, and never at phase 0
    assign blend_mode = i_linear && (shift != '0) && (i_phase != '0);

    assign n_val    = WGT_W'(1) << shift;
    assign wgt_cur  = {1'b0, i_phase};
    assign wgt_prev = n_val - wgt_cur;

    // prev*(N-k) + cur*k
    assign blend = prev_q * $signed({1'b0, wgt_prev})
                 + cur * $signed({1'b0, wgt_cur});

    assign blend_sh = blend >>> shift;  // exact divide by N

    always_comb begin
        if (blend_mode) begin
            sample_nxt = blend_sh[SAMPLE_W-1:0];
        end else begin
            sample_nxt = cur;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dac_data <= '0;
        end else if (i_play_tick) begin
            o_dac_data <= sample_nxt;
        end
    end

    // left end of the blend, taken at phase 0
    always_ff @(posedge i_clk) begin
        if (i_play_tick && i_linear && (i_phase == '0)) begin
            prev_q <= cur;
        end
    end

endmodule

`default_nettype wire

// File: verilog/aud_dsp.sv
`timescale 1ns/100ps
`default_nettype none

module aud_dsp
    import aud_pkg::*;
(
    input  wire                 i_clk,
    input  wire                 i_rst_n,
    input  wire                 i_start,
    input  wire                 i_pause,
    input  wire                 i_stop,
    input  wire speed_t         i_speed,
    input  wire                 i_linear,
    input  wire                 i_daclrck,
    input  wire [SAMPLE_W-1:0]  i_sram_data,
    input  wire                 i_player_ack,
    input  wire [ADDR_W-1:0]    i_last_addr,
    output logic [SAMPLE_W-1:0] o_dac_data,
    output logic [ADDR_W-1:0]   o_sram_addr,
    output logic                o_player_en
);

    logic               play_tick;
    speed_t             speed;
    logic               clear;
    logic               end_hit;
    logic [PHASE_W-1:0] phase;

    play_ctrl u_play_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_pause      (i_pause),
        .i_stop       (i_stop),
        .i_daclrck    (i_daclrck),
        .i_player_ack (i_player_ack),
        .i_speed      (i_speed),
        .i_end_hit    (end_hit),
        .o_play_tick  (play_tick),
        .o_speed      (speed),
        .o_clear      (clear),
        .o_player_en  (o_player_en)
    );

    addr_seq u_addr_seq (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_play_tick (play_tick),
        .i_clear     (clear),
        .i_speed     (speed),
        .i_linear    (i_linear),
        .i_last_addr (i_last_addr),
        .o_sram_addr (o_sram_addr),
        .o_phase     (phase),
        .o_end_hit   (end_hit)
    );

    // sram word at o_sram_addr feeds the interpolator directly
    interp u_interp (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_play_tick (play_tick),
        .i_speed     (speed),
        .i_linear    (i_linear),
        .i_phase     (phase),
        .i_sram_data (i_sram_data),
        .o_dac_data  (o_dac_data)
    );

endmodule

`default_nettype wire

// File: bench/aud_dsp_props.sv
`timescale 1ns/100ps
`default_nettype none

module aud_dsp_props
    import aud_pkg::*;
(
    input wire         i_clk,
    input wire         i_rst_n,
    input wire         i_play_tick,
    input wire         i_player_en,
    input wire state_t i_state
);

    // a sample flag only comes from a playing tick
    a_en_after_tick: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_player_en) |-> $past(i_play_tick)
    ) else $error("o_player_en rose without a play tick");

    a_stop_one_cycle: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_state == ST_STOP) |=> (i_state == ST_IDLE)
    ) else $error("ST_STOP lasted more than one cycle");

    // paused engine never announces a sample
    a_pause_quiet: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_state == ST_PAUSE) |=> !i_player_en
    ) else $error("o_player_en high after a cycle in ST_PAUSE");

endmodule

`default_nettype wire

// File: bench/tb_aud_dsp.sv
`timescale 1ns/100ps
`default_nettype none

module tb_aud_dsp
    import aud_pkg::*;
();

    localparam int CLK_NS      = 8;
    localparam int LRCK_HALF   = 10;  // i_clk cycles per lrck level
    localparam int LRCK_CYCLES = 2 * LRCK_HALF;
    localparam int MEM_WORDS   = 64;
    localparam int SAMPLE_WAIT = 50;  // cycles allowed for one sample
    // samples per test, quiet windows counted as lrck periods
    localparam int SAMPLE_COUNT = 5 + 12 + 12 + 24 + 11 + 7;
    localparam int WATCHDOG_NS  = SAMPLE_COUNT * LRCK_CYCLES * CLK_NS * 2;

    logic                i_clk;
    logic                i_rst_n;
    logic                i_start;
    logic                i_pause;
    logic                i_stop;
    speed_t              i_speed;
    logic                i_linear;
    logic                i_daclrck;
    logic [SAMPLE_W-1:0] i_sram_data;
    logic                i_player_ack;
    logic [ADDR_W-1:0]   i_last_addr;
    logic [SAMPLE_W-1:0] o_dac_data;
    logic [ADDR_W-1:0]   o_sram_addr;
    logic                o_player_en;

    logic [SAMPLE_W-1:0] mem [MEM_WORDS];
    int                  seed;
    int                  errors;

    // reference model
    int     ref_addr;
    int     ref_phase;
    int     ref_prev;
    speed_t ref_speed;
    bit     ref_linear;

    aud_dsp u_aud_dsp (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_pause      (i_pause),
        .i_stop       (i_stop),
        .i_speed      (i_speed),
        .i_linear     (i_linear),
        .i_daclrck    (i_daclrck),
        .i_sram_data  (i_sram_data),
        .i_player_ack (i_player_ack),
        .i_last_addr  (i_last_addr),
        .o_dac_data   (o_dac_data),
        .o_sram_addr  (o_sram_addr),
        .o_player_en  (o_player_en)
    );

    bind play_ctrl aud_dsp_props u_props (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_play_tick (o_play_tick),
        .i_player_en (o_player_en),
        .i_state     (state_q)
    );

    assign i_sram_data = mem[o_sram_addr[5:0]];  // asynchronous sram read

    initial begin
        i_clk = 1'b0;
        forever #(CLK_NS / 2) i_clk = ~i_clk;
    end

    // free-running left/right clock
    initial begin
        i_daclrck = 1'b0;
        forever begin
            repeat (LRCK_HALF) @(posedge i_clk);
            #1;
            i_daclrck = ~i_daclrck;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished, %0d errors so far", errors);
        $display("sim failed");
        $finish;
    end

    task automatic step_clk();
        @(posedge i_clk);
        #1;
    endtask

    // next sample per the speed rules, advances the reference
    task automatic predict_sample(output logic [SAMPLE_W-1:0] exp_data);
        int sh;
        int stride;
        int n;
        int cur;
        int adv;
        int blend;
        sh     = 0;
        stride = 1;
        case (ref_speed)
            SPD_HALF:    sh = 1;
            SPD_QUARTER: sh = 2;
            SPD_EIGHTH:  sh = 3;
            SPD_X1, SPD_X2, SPD_X3, SPD_X4,
            SPD_X5, SPD_X6, SPD_X7, SPD_X8: stride = int'(ref_speed) / 8;
            default:     stride = 1;
        endcase
        n        = 1 << sh;
        cur      = int'($signed(mem[ref_addr % MEM_WORDS]));
        adv      = 0;
        exp_data = cur[SAMPLE_W-1:0];
        if (sh == 0) begin
            adv = stride;
        end else if (!ref_linear) begin
            adv = (ref_phase == n - 1) ? 1 : 0;  // move on after N repeats
        end else if (ref_phase == 0) begin
            ref_prev = cur;
            adv      = 1;
        end else begin
            blend    = ref_prev * (n - ref_phase) + cur * ref_phase;
            blend    = blend >>> sh;
            exp_data = blend[SAMPLE_W-1:0];
        end
        if (ref_addr + adv <= int'(i_last_addr)) begin
            ref_addr = ref_addr + adv;  // past the last word the address holds
        end
        ref_phase = (sh == 0 || ref_phase == n - 1) ? 0 : ref_phase + 1;
    endtask

    task automatic check_sample();
        logic [SAMPLE_W-1:0] exp_data;
        int                  waited;
        waited = 0;
        while (!o_player_en && waited < SAMPLE_WAIT) begin
            step_clk();
            waited++;
        end
        if (!o_player_en) begin
            $display("no sample arrived within %0d cycles at %0t", SAMPLE_WAIT, $time);
            errors++;
            return;
        end
        predict_sample(exp_data);
        if (o_dac_data !== exp_data) begin
            $display("Fail o_dac_data: got %h expected %h", o_dac_data, exp_data);
            errors++;
        end
        if (o_sram_addr !== ADDR_W'(ref_addr)) begin
            $display("Fail o_sram_addr: got %h expected %h", o_sram_addr, ADDR_W'(ref_addr));
            errors++;
        end
        step_clk();
        step_clk();
        i_player_ack = 1'b1;  // player takes the sample
        step_clk();
        i_player_ack = 1'b0;
        if (o_player_en !== 1'b0) begin
            $display("o_player_en stayed high after i_player_ack at %0t", $time);
            errors++;
        end
    endtask

    task automatic check_samples(input int count);
        repeat (count) check_sample();
    endtask

    task automatic expect_no_sample(input int cycles, input string what);
        for (int i = 0; i < cycles; i++) begin
            step_clk();
            if (o_player_en) begin
                $display("unexpected sample %s at %0t", what, $time);
                errors++;
                break;
            end
        end
    endtask

    task automatic check_addr_zero();
        if (o_sram_addr !== START_ADDR) begin
            $display("Fail o_sram_addr: got %h expected %h", o_sram_addr, START_ADDR);
            errors++;
        end
    endtask

    task automatic start_play(input speed_t spd, input bit linear);
        i_speed    = spd;
        i_linear   = linear;
        ref_speed  = spd;
        ref_linear = linear;
        ref_addr   = 0;
        ref_phase  = 0;
        ref_prev   = 0;
        i_start    = 1'b1;
        step_clk();
        i_start = 1'b0;
    endtask

    task automatic stop_play();
        i_stop = 1'b1;
        step_clk();
        i_stop = 1'b0;
        repeat (3) step_clk();  // stop, idle, then the address clear
        check_addr_zero();
    endtask

    task automatic test_reset_idle();
        if (o_player_en !== 1'b0) begin
            $display("Fail o_player_en: got %h expected %h", o_player_en, 1'b0);
            errors++;
        end
        if (o_dac_data !== '0) begin
            $display("Fail o_dac_data: got %h expected %h", o_dac_data, SAMPLE_W'(0));
            errors++;
        end
        check_addr_zero();
        expect_no_sample(5 * LRCK_CYCLES, "without i_start");
    endtask

    task automatic test_fast();
        start_play(SPD_X1, 1'b0);
        check_samples(6);
        stop_play();
        start_play(SPD_X3, 1'b0);
        check_samples(6);
        stop_play();
    endtask

    task automatic test_slow_hold();
        start_play(SPD_QUARTER, 1'b0);
        check_samples(12);
        stop_play();
    endtask

    task automatic test_slow_linear();
        start_play(SPD_HALF, 1'b1);
        check_samples(8);
        stop_play();
        start_play(SPD_EIGHTH, 1'b1);
        check_samples(16);
        stop_play();
        i_linear = 1'b0;
    endtask

    task automatic test_pause_resume_stop();
        start_play(SPD_X2, 1'b0);
        check_samples(3);
        i_pause = 1'b1;
        step_clk();
        i_pause = 1'b0;
        expect_no_sample(3 * LRCK_CYCLES, "while paused");
        i_start = 1'b1;  // resume, reference carries on
        step_clk();
        i_start = 1'b0;
        check_samples(3);
        stop_play();
        expect_no_sample(2 * LRCK_CYCLES, "after stop");
        check_addr_zero();
    endtask

    task automatic test_end_of_recording();
        i_last_addr = ADDR_W'(11);
        start_play(SPD_X3, 1'b0);
        check_samples(4);  // words 0, 3, 6 and 9
        check_addr_zero();  // back in idle right after the last word
        expect_no_sample(3 * LRCK_CYCLES, "after end of recording");
        check_addr_zero();
        i_last_addr = ADDR_W'(MEM_WORDS - 1);
    endtask

    initial begin
        seed = 32'h1d4b_9919;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = SAMPLE_W'($random(seed));
        end
        errors       = 0;
        i_rst_n      = 1'b0;
        i_start      = 1'b0;
        i_pause      = 1'b0;
        i_stop       = 1'b0;
        i_speed      = SPD_X1;
        i_linear     = 1'b0;
        i_player_ack = 1'b0;
        i_last_addr  = ADDR_W'(MEM_WORDS - 1);
        repeat (2) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;

        test_reset_idle();
        test_fast();
        test_slow_hold();
        test_slow_linear();
        test_pause_resume_stop();
        test_end_of_recording();

        $display("tests done, errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
verilog/aud_pkg.sv
verilog/play_ctrl.sv
verilog/addr_seq.sv
verilog/interp.sv
verilog/aud_dsp.sv
bench/aud_dsp_props.sv
bench/tb_aud_dsp.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_aud_dsp -f all.f -o vsim \
    || { echo "verilator build error"; exit 1; }
./obj_dir/vsim > sim.log 2>&1
cat sim.log
grep -qx "sim passed" sim.log && echo "run.sh: pass" || { echo "run.sh: fail"; exit 1; }
